// File: csr_unit.f
+incdir+include
rtl/csr_pkg.sv
rtl/csr_exc_ctrl.sv
rtl/csr_int_ctrl.sv
rtl/csr_timer.sv
rtl/csr_scratch.sv
rtl/csr_unit.sv
verif/csr_unit_chk.sv
verif/csr_unit_tb.sv

// File: include/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define CSR_NUM_W       14
`define CSR_DATA_W      32
`define ECODE_W         6
`define ESUB_W          9

`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

`define ECODE_ADE       6'h08
`define ECODE_ALE       6'h09
`define ESUB_ADEF       9'h000

`define INT_LINES       13
`define INT_TIMER_BIT   11
`define INT_IPI_BIT     12
`define ECFG_LIE_MASK   13'h1bff
`define EENTRY_LSB      6
`define CRMD_RESET      9'h008
`define TIMER_IDLE      32'hffffffff

`endif

// File: rtl/csr_exc_ctrl.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_exc_ctrl
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_wr_t                wr,
    input  exc_info_t              exc,
    input  logic [`INT_LINES-1:0]  int_status,
    output logic [`CSR_DATA_W-1:0] rdata,
    output crmd_t                  crmd,
    output logic [`CSR_DATA_W-1:0] eentry
);

    localparam int CRMD_W = $bits(crmd_t);
    localparam int VA_W   = `CSR_DATA_W - `EENTRY_LSB;

    logic [1:0]             pplv_q;
    logic                   pie_q;
    logic [`ECODE_W-1:0]    ecode_q;
    logic [`ESUB_W-1:0]     esub_q;
    logic [`CSR_DATA_W-1:0] era_q;
    logic [`CSR_DATA_W-1:0] badv_q;
    logic [VA_W-1:0]        eentry_va_q;
    logic [`CSR_DATA_W-1:0] wdata;
    logic                   addr_err;
    logic                   badv_from_pc;

    // masked merge against the addressed register's old value
    always_comb
    begin
        case (wr.num)
            `CSR_CRMD:   wdata = {{(`CSR_DATA_W-CRMD_W){1'b0}}, crmd};
            `CSR_PRMD:   wdata = {29'b0, pie_q, pplv_q};
            `CSR_ERA:    wdata = era_q;
            `CSR_BADV:   wdata = badv_q;
            default:     wdata = eentry;
        endcase
        wdata = (wr.wmask & wr.wvalue) | (~wr.wmask & wdata);
    end

    assign addr_err     = (exc.ecode == `ECODE_ADE) || (exc.ecode == `ECODE_ALE);
    assign badv_from_pc = (exc.ecode == `ECODE_ADE) && (exc.esubcode == `ESUB_ADEF);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            crmd        <= crmd_t'(`CRMD_RESET);
            pplv_q      <= '0;
            pie_q       <= 1'b0;
            ecode_q     <= '0;
            esub_q      <= '0;
            era_q       <= '0;
            badv_q      <= '0;
            eentry_va_q <= '0;
        end
        else
        begin
            // exception entry beats ertn, ertn beats a software write
            if (exc.ex)
            begin
                crmd.plv <= 2'b0;
                crmd.ie  <= 1'b0;
                pplv_q   <= crmd.plv;
                pie_q    <= crmd.ie;
                ecode_q  <= exc.ecode;
                esub_q   <= exc.esubcode;
                era_q    <= exc.pc;
            end
            else if (exc.ertn)
            begin
                crmd.plv <= pplv_q;
                crmd.ie  <= pie_q;
            end
            else if (wr.we && wr.num == `CSR_CRMD)
                crmd <= crmd_t'(wdata[CRMD_W-1:0]);

            if (!exc.ex && wr.we && wr.num == `CSR_PRMD)
                {pie_q, pplv_q} <= wdata[2:0];
            if (!exc.ex && wr.we && wr.num == `CSR_ERA)
                era_q <= wdata;

            // badv only for address errors
            if (exc.ex && addr_err)
                badv_q <= badv_from_pc ? exc.pc : exc.vaddr;
            else if (wr.we && wr.num == `CSR_BADV)
                badv_q <= wdata;

            if (wr.we && wr.num == `CSR_EENTRY)
                eentry_va_q <= wdata[`CSR_DATA_W-1:`EENTRY_LSB];
        end
    end

    assign eentry = {eentry_va_q, {`EENTRY_LSB{1'b0}}};

    always_comb
    begin
        case (wr.num)
            `CSR_CRMD:   rdata = {{(`CSR_DATA_W-CRMD_W){1'b0}}, crmd};
            `CSR_PRMD:   rdata = {29'b0, pie_q, pplv_q};
            `CSR_ESTAT:  rdata = {1'b0, esub_q, ecode_q, 3'b0, int_status[12:11], 1'b0,
                                  int_status[9:0]};
            `CSR_ERA:    rdata = era_q;
            `CSR_BADV:   rdata = badv_q;
            `CSR_EENTRY: rdata = eentry;
            default:     rdata = '0;
        endcase
    end

endmodule

// File: rtl/csr_int_ctrl.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_int_ctrl
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_wr_t                wr,
    input  logic [7:0]             hw_int,
    input  logic                   ipi_int,
    input  logic                   timer_pending,
    input  crmd_t                  crmd,
    output logic [`CSR_DATA_W-1:0] rdata,
    output logic [`INT_LINES-1:0]  int_status,
    output logic                   has_int
);

    logic [`INT_LINES-1:0] lie_q;
    logic [1:0]            swi_q;
    logic [7:0]            hw_q;
    logic                  ipi_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lie_q <= '0;
            swi_q <= '0;
            hw_q  <= '0;
            ipi_q <= 1'b0;
        end
        else
        begin
            // lie bit 10 stays zero
            if (wr.we && wr.num == `CSR_ECFG)
                lie_q <= ((wr.wmask[`INT_LINES-1:0] & wr.wvalue[`INT_LINES-1:0])
                         | (~wr.wmask[`INT_LINES-1:0] & lie_q)) & `ECFG_LIE_MASK;
            if (wr.we && wr.num == `CSR_ESTAT)
                swi_q <= (wr.wmask[1:0] & wr.wvalue[1:0]) | (~wr.wmask[1:0] & swi_q);
            hw_q  <= hw_int;
            ipi_q <= ipi_int;
        end
    end

    always_comb
    begin
        int_status                 = '0;
        int_status[1:0]            = swi_q;
        int_status[9:2]            = hw_q;
        int_status[`INT_TIMER_BIT] = timer_pending;
        int_status[`INT_IPI_BIT]   = ipi_q;
    end

    assign has_int = (|(int_status[`INT_IPI_BIT-1:0] & lie_q[`INT_IPI_BIT-1:0])) && crmd.ie;
    assign rdata   = (wr.num == `CSR_ECFG) ? {{(`CSR_DATA_W-`INT_LINES){1'b0}}, lie_q} : '0;

endmodule

// File: rtl/csr_pkg.sv
`include "csr_consts.svh"

package csr_pkg;

    // one software write request, fanned out to every group
    typedef struct packed {
        logic                   we;
        logic [`CSR_NUM_W-1:0]  num;
        logic [`CSR_DATA_W-1:0] wmask;
        logic [`CSR_DATA_W-1:0] wvalue;
    } csr_wr_t;

    // writeback exception event plus ertn strobe
    typedef struct packed {
        logic                   ex;
        logic                   ertn;
        logic [`ECODE_W-1:0]    ecode;
        logic [`ESUB_W-1:0]     esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] vaddr;
    } exc_info_t;

    // same bit layout as the crmd register
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

endpackage

// File: rtl/csr_scratch.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_scratch
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_wr_t                wr,
    output logic [`CSR_DATA_W-1:0] rdata
);

    logic [`CSR_DATA_W-1:0] save_q [4];
    logic                   hit;
    logic [1:0]             idx;

    // save0..save3 sit on consecutive numbers
    assign hit = (wr.num >= `CSR_SAVE0) && (wr.num <= `CSR_SAVE3);
    assign idx = 2'(wr.num - `CSR_SAVE0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
        end
        else if (wr.we && hit)
            save_q[idx] <= (wr.wmask & wr.wvalue) | (~wr.wmask & save_q[idx]);
    end

    assign rdata = hit ? save_q[idx] : '0;

endmodule

// File: rtl/csr_timer.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_timer
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_wr_t                wr,
    output logic [`CSR_DATA_W-1:0] rdata,
    output logic                   timer_pending
);

    logic                   en_q;
    logic                   periodic_q;
    logic [29:0]            initval_q;
    logic [`CSR_DATA_W-1:0] cnt_q;
    logic [`CSR_DATA_W-1:0] tcfg;
    logic [`CSR_DATA_W-1:0] tcfg_next;
    logic                   tcfg_wr;
    logic                   ticlr_clr;
    logic                   cnt_zero;

    assign tcfg      = {initval_q, periodic_q, en_q};
    assign tcfg_next = (wr.wmask & wr.wvalue) | (~wr.wmask & tcfg);
    assign tcfg_wr   = wr.we && (wr.num == `CSR_TCFG);
    assign ticlr_clr = wr.we && (wr.num == `CSR_TICLR) && wr.wmask[0] && wr.wvalue[0];
    assign cnt_zero  = (cnt_q == '0);

    always_ff @(posedge clk)
    begin
        if (reset)
            {initval_q, periodic_q, en_q} <= '0;
        else if (tcfg_wr)
            {initval_q, periodic_q, en_q} <= tcfg_next;
    end

    // count is initval*4, idles at all ones
    always_ff @(posedge clk)
    begin
        if (reset)
            cnt_q <= `TIMER_IDLE;
        else if (tcfg_wr && tcfg_next[0])
            cnt_q <= {tcfg_next[`CSR_DATA_W-1:2], 2'b0};
        else if (en_q && cnt_q != `TIMER_IDLE)
        begin
            if (cnt_zero && periodic_q)
                cnt_q <= {initval_q, 2'b0};
            else
                cnt_q <= cnt_q - 1'b1;
        end
    end

    // expiry wins over a same-cycle clear
    always_ff @(posedge clk)
    begin
        if (reset)
            timer_pending <= 1'b0;
        else if (cnt_zero)
            timer_pending <= 1'b1;
        else if (ticlr_clr)
            timer_pending <= 1'b0;
    end

    always_comb
    begin
        case (wr.num)
            `CSR_TCFG: rdata = tcfg;
            `CSR_TVAL: rdata = cnt_q;
            default:   rdata = '0;
        endcase
    end

endmodule

// File: rtl/csr_unit.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   csr_re,
    input  logic [`CSR_NUM_W-1:0]  csr_num,
    output logic [`CSR_DATA_W-1:0] csr_rvalue,
    input  logic                   csr_we,
    input  logic [`CSR_DATA_W-1:0] csr_wmask,
    input  logic [`CSR_DATA_W-1:0] csr_wvalue,
    input  logic                   wb_ex,
    input  logic [`ECODE_W-1:0]    wb_ecode,
    input  logic [`ESUB_W-1:0]     wb_esubcode,
    input  logic [`CSR_DATA_W-1:0] wb_pc,
    input  logic [`CSR_DATA_W-1:0] wb_vaddr,
    input  logic                   ertn_flush,
    input  logic [7:0]             hw_int_in,
    input  logic                   ipi_int_in,
    output logic                   has_int,
    output logic [`CSR_DATA_W-1:0] csr_eentry,
    output logic [`CSR_DATA_W-1:0] csr_crmd
);

    csr_wr_t                wr;
    exc_info_t              exc;
    crmd_t                  crmd;
    logic [`INT_LINES-1:0]  int_status;
    logic                   timer_pending;
    logic [`CSR_DATA_W-1:0] exc_rdata;
    logic [`CSR_DATA_W-1:0] int_rdata;
    logic [`CSR_DATA_W-1:0] tmr_rdata;
    logic [`CSR_DATA_W-1:0] scr_rdata;

    assign wr = '{we: csr_we, num: csr_num, wmask: csr_wmask, wvalue: csr_wvalue};
    assign exc = '{ex: wb_ex, ertn: ertn_flush, ecode: wb_ecode, esubcode: wb_esubcode,
                   pc: wb_pc, vaddr: wb_vaddr};

    csr_exc_ctrl exc_ctrl_i (
        .clk(clk), .reset(reset), .wr(wr), .exc(exc), .int_status(int_status),
        .rdata(exc_rdata), .crmd(crmd), .eentry(csr_eentry)
    );

    csr_int_ctrl int_ctrl_i (
        .clk(clk), .reset(reset), .wr(wr), .hw_int(hw_int_in), .ipi_int(ipi_int_in),
        .timer_pending(timer_pending), .crmd(crmd),
        .rdata(int_rdata), .int_status(int_status), .has_int(has_int)
    );

    csr_timer timer_i (
        .clk(clk), .reset(reset), .wr(wr), .rdata(tmr_rdata), .timer_pending(timer_pending)
    );

    csr_scratch scratch_i (.clk(clk), .reset(reset), .wr(wr), .rdata(scr_rdata));

    // groups return zero when not addressed
    assign csr_rvalue = csr_re ? (exc_rdata | int_rdata | tmr_rdata | scr_rdata) : '0;
    assign csr_crmd   = {{(`CSR_DATA_W-$bits(crmd_t)){1'b0}}, crmd};

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the csr_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert --top-module csr_unit_tb -f csr_unit.f -o csr_unit_sim; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can count them
./obj_dir/csr_unit_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: verif/csr_unit_chk.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit_chk
    import csr_pkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input logic                   wb_ex,
    input logic                   ertn_flush,
    input logic                   has_int,
    input logic [`CSR_DATA_W-1:0] csr_crmd
);

    int    fail_count = 0;
    crmd_t crmd;

    assign crmd = crmd_t'(csr_crmd[$bits(crmd_t)-1:0]);

    reset_state_a: assert property (@(posedge clk) reset |=> (crmd.da && !crmd.ie))
    else
    begin
        fail_count++;
        $error("crmd not at its reset value after reset");
    end

    // ie is cleared on entry so no interrupt can be raised
    ex_int_off_a: assert property (@(posedge clk) disable iff (reset) wb_ex |=> !has_int)
    else
    begin
        fail_count++;
        $error("has_int high right after exception entry");
    end

    // entry always drops to kernel level
    ex_plv_a: assert property (@(posedge clk) disable iff (reset) wb_ex |=> crmd.plv == 2'b00)
    else
    begin
        fail_count++;
        $error("crmd.plv not zero after exception entry");
    end

    // ertn touches only plv and ie
    ertn_mode_a: assert property (@(posedge clk) disable iff (reset)
        (ertn_flush && !wb_ex) |=> csr_crmd[31:3] == $past(csr_crmd[31:3]))
    else
    begin
        fail_count++;
        $error("crmd fields other than plv and ie changed on ertn");
    end

endmodule

// File: verif/csr_unit_tb.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit_tb
    import csr_pkg::*;
();

    localparam int N_WR   = 300;
    localparam int N_EXC  = 60;
    localparam int N_ERTN = 20;
    localparam int N_TMR  = 6;
    localparam int N_INT  = 300;
    localparam int N_RE   = 100;
    // a timer run takes at most about 55 cycles
    localparam int EST_CYCLES = 2 * N_WR + 7 * N_EXC + 4 * N_ERTN + 55 * N_TMR
                                + 2 * N_INT + N_RE;
    localparam int MAX_CYCLES = 3 * EST_CYCLES;
    localparam logic [`CSR_NUM_W-1:0] KEPT [14] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG,
        `CSR_ESTAT, `CSR_ERA, `CSR_BADV, `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2,
        `CSR_SAVE3, `CSR_TCFG, `CSR_TVAL, `CSR_TICLR};

    logic                   clk;
    logic                   reset;
    logic                   csr_re;
    logic [`CSR_NUM_W-1:0]  csr_num;
    logic [`CSR_DATA_W-1:0] csr_rvalue;
    logic                   csr_we;
    logic [`CSR_DATA_W-1:0] csr_wmask;
    logic [`CSR_DATA_W-1:0] csr_wvalue;
    logic                   wb_ex;
    logic [`ECODE_W-1:0]    wb_ecode;
    logic [`ESUB_W-1:0]     wb_esubcode;
    logic [`CSR_DATA_W-1:0] wb_pc;
    logic [`CSR_DATA_W-1:0] wb_vaddr;
    logic                   ertn_flush;
    logic [7:0]             hw_int_in;
    logic                   ipi_int_in;
    logic                   has_int;
    logic [`CSR_DATA_W-1:0] csr_eentry;
    logic [`CSR_DATA_W-1:0] csr_crmd;

    // reference model state
    crmd_t       m_crmd;
    logic [2:0]  m_prmd;
    logic [12:0] m_lie;
    logic [1:0]  m_swi;
    logic [7:0]  m_hw;
    logic        m_ipi;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_tcfg;
    logic [31:0] m_cnt;
    logic        m_tpend;
    logic [31:0] m_save [4];

    logic [31:0] seed = 32'ha16c5280;
    logic [31:0] last_read;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    csr_unit dut_i (.*);

    bind csr_unit csr_unit_chk chk_i (
        .clk(clk), .reset(reset), .wb_ex(wb_ex), .ertn_flush(ertn_flush),
        .has_int(has_int), .csr_crmd(csr_crmd)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] masked_merge(input logic [31:0] old);
        return (csr_wvalue & csr_wmask) | (old & ~csr_wmask);
    endfunction

    function automatic logic [31:0] model_read(input logic [`CSR_NUM_W-1:0] num);
        case (num)
            `CSR_CRMD:   return {23'b0, m_crmd};
            `CSR_PRMD:   return {29'b0, m_prmd};
            `CSR_ECFG:   return {19'b0, m_lie};
            `CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b0, m_ipi, m_tpend, 1'b0, m_hw, m_swi};
            `CSR_ERA:    return m_era;
            `CSR_BADV:   return m_badv;
            `CSR_EENTRY: return m_eentry;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3: return m_save[num[1:0]];
            `CSR_TCFG:   return m_tcfg;
            `CSR_TVAL:   return m_cnt;
            default:     return 32'b0;
        endcase
    endfunction

    task automatic model_reset();
        m_crmd    = '0;
        m_crmd.da = 1'b1;
        m_prmd    = '0;
        m_lie     = '0;
        m_swi     = '0;
        m_hw      = '0;
        m_ipi     = 1'b0;
        m_ecode   = '0;
        m_esub    = '0;
        m_era     = '0;
        m_badv    = '0;
        m_eentry  = '0;
        m_tcfg    = '0;
        m_cnt     = `TIMER_IDLE;
        m_tpend   = 1'b0;
        for (int i = 0; i < 4; i++)
            m_save[i] = '0;
    endtask

    // next state from the inputs captured at the coming edge
    task automatic model_update();
        logic [31:0] tcfg_new;
        logic [31:0] nv;
        tcfg_new = masked_merge(m_tcfg);
        if (m_cnt == 32'd0)
            m_tpend = 1'b1;
        else if (csr_we && csr_num == `CSR_TICLR && csr_wmask[0] && csr_wvalue[0])
            m_tpend = 1'b0;
        if (csr_we && csr_num == `CSR_TCFG && tcfg_new[0])
            m_cnt = {tcfg_new[31:2], 2'b00};
        else if (m_tcfg[0] && m_cnt != `TIMER_IDLE)
            m_cnt = (m_cnt == 32'd0 && m_tcfg[1]) ? {m_tcfg[31:2], 2'b00} : m_cnt - 32'd1;
        m_hw  = hw_int_in;
        m_ipi = ipi_int_in;
        if (wb_ex)
        begin
            m_prmd     = {m_crmd.ie, m_crmd.plv};
            m_crmd.ie  = 1'b0;
            m_crmd.plv = 2'b00;
            m_ecode    = wb_ecode;
            m_esub     = wb_esubcode;
            m_era      = wb_pc;
            if (wb_ecode == `ECODE_ADE || wb_ecode == `ECODE_ALE)
                m_badv = (wb_ecode == `ECODE_ADE && wb_esubcode == `ESUB_ADEF) ? wb_pc : wb_vaddr;
        end
        else if (ertn_flush)
        begin
            m_crmd.plv = m_prmd[1:0];
            m_crmd.ie  = m_prmd[2];
        end
        if (csr_we)
        begin
            nv = masked_merge(model_read(csr_num));
            case (csr_num)
                `CSR_CRMD:   m_crmd = crmd_t'(nv[8:0]);
                `CSR_PRMD:   m_prmd = nv[2:0];
                `CSR_ECFG:   m_lie = nv[12:0] & 13'h1bff;
                `CSR_ESTAT:  m_swi = nv[1:0];
                `CSR_ERA:    m_era = nv;
                `CSR_BADV:   m_badv = nv;
                `CSR_EENTRY: m_eentry = nv & 32'hffffffc0;
                `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3: m_save[csr_num[1:0]] = nv;
                `CSR_TCFG:   m_tcfg = nv;
                default:     ;
            endcase
        end
    endtask

    task automatic step_cycle();
        model_update();
        @(posedge clk);
        #1;
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic write_csr(input logic [`CSR_NUM_W-1:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        csr_we     = 1'b1;
        csr_num    = num;
        csr_wmask  = mask;
        csr_wvalue = value;
        step_cycle();
        csr_we = 1'b0;
    endtask

    task automatic check_read(input logic [`CSR_NUM_W-1:0] num);
        logic [31:0] exp;
        csr_re  = 1'b1;
        csr_num = num;
        #1;
        exp = model_read(num);
        checks++;
        if (csr_rvalue !== exp)
            report_error($sformatf("csr %0h read %08h, expected %08h", num, csr_rvalue, exp));
        last_read = csr_rvalue;
        step_cycle();
        csr_re = 1'b0;
    endtask

    initial
    begin
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        logic [`CSR_NUM_W-1:0] num;
        logic [31:0]           r;
        logic [31:0]           mask;
        logic [31:0]           value;
        logic [31:0]           exp_tval;
        logic [29:0]           initval;
        logic                  periodic;
        logic                  exp_int;
        reset       = 1'b1;
        csr_re      = 1'b0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        model_reset();
        if (has_int !== 1'b0)
            report_error("has_int set after reset");
        check_read(`CSR_CRMD);

        // masked write and readback
        for (int i = 0; i < N_WR; i++)
        begin
            num   = KEPT[4'(next_rand() % 32'd14)];
            mask  = next_rand();
            value = next_rand();
            write_csr(num, mask, value);
            check_read(num);
            checks++;
            if (csr_eentry !== m_eentry)
                report_error($sformatf("csr_eentry %08h, expected %08h", csr_eentry, m_eentry));
        end

        // exception entry
        for (int i = 0; i < N_EXC; i++)
        begin
            write_csr(`CSR_CRMD, 32'h7, next_rand());
            r           = next_rand();
            wb_ecode    = (r[1:0] == 2'd0) ? `ECODE_ADE : (r[1:0] == 2'd1) ? `ECODE_ALE : r[13:8];
            wb_esubcode = r[2] ? `ESUB_ADEF : r[24:16];
            wb_pc       = next_rand();
            wb_vaddr    = next_rand();
            wb_ex       = 1'b1;
            step_cycle();
            wb_ex = 1'b0;
            check_read(`CSR_CRMD);
            check_read(`CSR_PRMD);
            check_read(`CSR_ESTAT);
            check_read(`CSR_ERA);
            check_read(`CSR_BADV);
        end

        // ertn restores plv and ie only
        for (int i = 0; i < N_ERTN; i++)
        begin
            write_csr(`CSR_PRMD, 32'h7, next_rand());
            write_csr(`CSR_CRMD, 32'h1ff, next_rand());
            ertn_flush = 1'b1;
            step_cycle();
            ertn_flush = 1'b0;
            checks++;
            if (csr_crmd !== {23'b0, m_crmd})
                report_error($sformatf("csr_crmd %08h after ertn, expected %03h",
                                       csr_crmd, m_crmd));
            check_read(`CSR_CRMD);
        end

        // timer with odd runs periodic
        for (int i = 0; i < N_TMR; i++)
        begin
            initval  = 30'(32'd2 + next_rand() % 32'd10);
            periodic = i[0];
            write_csr(`CSR_TCFG, '1, {initval, periodic, 1'b1});
            exp_tval = {initval, 2'b00};
            repeat (4 * int'(initval) + 3)
            begin
                check_read(`CSR_TVAL);
                if (last_read !== exp_tval)
                    report_error($sformatf("tval %08h, expected %08h", last_read, exp_tval));
                if (exp_tval == 32'd0)
                    exp_tval = periodic ? {initval, 2'b00} : `TIMER_IDLE;
                else if (exp_tval != `TIMER_IDLE)
                    exp_tval = exp_tval - 32'd1;
            end
            check_read(`CSR_ESTAT);
            if (last_read[`INT_TIMER_BIT] !== 1'b1)
                report_error("estat timer bit not set after expiry");
            if (!periodic)
            begin
                check_read(`CSR_TVAL);
                if (last_read !== `TIMER_IDLE)
                    report_error($sformatf("one-shot tval %08h, expected all ones", last_read));
            end
            write_csr(`CSR_TICLR, 32'h1, 32'h1);
            check_read(`CSR_ESTAT);
            if (last_read[`INT_TIMER_BIT] !== 1'b0)
                report_error("estat timer bit still set after ticlr");
            write_csr(`CSR_TCFG, '1, 32'h0);
        end

        // interrupt lines are seen one cycle late
        for (int i = 0; i < N_INT; i++)
        begin
            r          = next_rand();
            hw_int_in  = r[7:0];
            ipi_int_in = r[8];
            num  = (r[10:9] == 2'd0) ? `CSR_ECFG : (r[10:9] == 2'd1) ? `CSR_ESTAT : `CSR_CRMD;
            mask = (num == `CSR_CRMD) ? 32'h4 : next_rand();
            write_csr(num, mask, next_rand());
            exp_int = (|({m_tpend, 1'b0, m_hw, m_swi} & m_lie[11:0])) && m_crmd.ie;
            checks++;
            if (has_int !== exp_int)
                report_error($sformatf("has_int %b, expected %b", has_int, exp_int));
            check_read(`CSR_ESTAT);
        end
        hw_int_in  = '0;
        ipi_int_in = 1'b0;

        // reads with csr_re low
        for (int i = 0; i < N_RE; i++)
        begin
            csr_num = KEPT[4'(next_rand() % 32'd14)];
            #1;
            checks++;
            if (csr_rvalue !== 32'd0)
                report_error($sformatf("csr %0h read %08h with csr_re low", csr_num, csr_rvalue));
            step_cycle();
        end

        $display("checks: %0d  errors: %0d  assertion failures: %0d", checks, errors,
                 dut_i.chk_i.fail_count);
        if (errors == 0 && dut_i.chk_i.fail_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
